/* rtl/jsp_pkg.sv */
/*
 * JTAG serial port shared definitions
 * Channel widths, vector types, default FIFO depth and FSM states
 */
package jsp_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int BYTE_W     = 8;  // Bits per channel byte
  localparam int DR_TAIL_W  = 7;  // Newest DR bits visible to the port
  localparam int COUNT_W    = 4;  // Word counts and FIFO levels
  localparam int BIT_CNT_W  = $clog2(BYTE_W);

  // Default FIFO depth
  // Must stay at 15 or less, a full FIFO still has to fit one nibble
  localparam int FIFO_DEPTH = 8;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [BYTE_W-1:0]    byte_t;     // Channel data byte
  typedef logic [COUNT_W-1:0]   count_t;    // Word count or fill/free level
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;  // Bit position within a byte
  typedef logic [DR_TAIL_W-1:0] dr_tail_t;  // Newest bit in MSB, older TDI bits below

  // Write path FSM, TDI into the receive FIFO
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT,    // Multi-device chains only, waits for the start bit
    WR_COUNTS,  // Host count word
    WR_XFER
  } wr_state_e;

  // Read path FSM, transmit FIFO out to TDO
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_COUNTS,  // Status byte on TDO
    RD_RDACK,   // Pop the byte just loaded
    RD_XFER
  } rd_state_e;

endpackage

/* rtl/jsp_byte_fifo.sv */
/*
 * Single-clock byte FIFO
 * Circular buffer with fill and free counts, head shown on data_o
 */
`timescale 1ns/1ps

module jsp_byte_fifo #(
  parameter int fifo_depth_p = jsp_pkg::FIFO_DEPTH
) (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            push_i,
  input  jsp_pkg::byte_t  data_i,
  input  logic            pop_i,
  output jsp_pkg::byte_t  data_o,   // Head entry
  output jsp_pkg::count_t count_o,  // Fill level
  output jsp_pkg::count_t free_o    // Space left
);

  localparam int ptr_w = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;

  typedef logic [ptr_w-1:0] ptr_t;

  jsp_pkg::byte_t  mem_q [fifo_depth_p];
  ptr_t            wr_ptr_q, rd_ptr_q;
  jsp_pkg::count_t count_q;

  // Counts must fit a nibble
  if (fifo_depth_p < 1 || fifo_depth_p > 15) begin : g_depth_chk
    $error("jsp_byte_fifo depth %0d out of range 1..15", fifo_depth_p);
  end

  // Pointer advance with wrap at any depth
  function automatic ptr_t ptr_next(input ptr_t p);
    if (p == ptr_t'(fifo_depth_p - 1))
      return '0;
    return p + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge tck_i) begin
    if (push_i)
      mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i)
        wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_i)
        rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or push and pop together
      endcase
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;
  assign free_o  = jsp_pkg::count_t'(fifo_depth_p) - count_q;

  // Writers and readers on both sides work from the levels
  a_no_overflow : assert property (@(posedge tck_i) disable iff (rst_i)
    push_i |-> (count_q != jsp_pkg::count_t'(fifo_depth_p)));
  a_no_underflow : assert property (@(posedge tck_i) disable iff (rst_i)
    pop_i |-> (count_q != '0));

endmodule

/* rtl/jsp_word_counters.sv */
/*
 * JTAG serial port word counters
 * Receive space, announced transmit bytes and host byte count
 */
`timescale 1ns/1ps

module jsp_word_counters (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              in_ld_i,
  input  logic              in_dec_i,
  input  logic              out_ld_i,
  input  logic              out_dec_i,
  input  logic              user_ld_i,
  input  logic              user_dec_i,
  input  jsp_pkg::count_t   rx_free_i,   // Receive FIFO space
  input  jsp_pkg::count_t   tx_count_i,  // Transmit FIFO fill level
  input  logic              tdi_i,
  input  jsp_pkg::dr_tail_t dr_tail_i,
  output logic              in_zero_o,
  output logic              out_zero_o,
  output logic              user_zero_o
);

  localparam int N_CNT = 3;  // In, out, user

  logic [N_CNT-1:0] ld;
  logic [N_CNT-1:0] dec;
  logic [N_CNT-1:0] zero;
  jsp_pkg::count_t  ld_val [N_CNT];
  jsp_pkg::count_t  cnt_q  [N_CNT];

  ////////////////////////////////////////
  // Counter inputs
  ////////////////////////////////////////

  assign ld  = {user_ld_i, out_ld_i, in_ld_i};
  assign dec = {user_dec_i, out_dec_i, in_dec_i};

  assign ld_val[0] = rx_free_i;
  assign ld_val[1] = tx_count_i;
  // Count word upper nibble, last four bits of the word shifted in
  assign ld_val[2] = {tdi_i, dr_tail_i[jsp_pkg::DR_TAIL_W-1 -: 3]};

  ////////////////////////////////////////
  // Load/decrement registers
  ////////////////////////////////////////

  for (genvar i = 0; i < N_CNT; i++) begin : g_cnt
    always_ff @(posedge tck_i or posedge rst_i) begin
      if (rst_i)
        cnt_q[i] <= '0;
      else if (ld[i])
        cnt_q[i] <= ld_val[i];  // Load wins over decrement
      else if (dec[i])
        cnt_q[i] <= cnt_q[i] - 1'b1;
    end

    assign zero[i] = (cnt_q[i] == '0);

    // Control must check the zero flag before it steps a counter
    a_no_underflow : assert property (@(posedge tck_i) disable iff (rst_i)
      dec[i] && !ld[i] |-> !zero[i]);
  end

  assign in_zero_o   = zero[0];
  assign out_zero_o  = zero[1];
  assign user_zero_o = zero[2];

endmodule

/* rtl/jsp_tdo_shifter.sv */
/*
 * JTAG serial port TDO shifter
 * Loads the status byte or a transmit byte, shifts out LSB first
 */
`timescale 1ns/1ps

module jsp_tdo_shifter (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            ld_i,          // Parallel load
  input  logic            shift_i,       // Shift right one bit
  input  logic            status_sel_i,  // Load status instead of data
  input  jsp_pkg::byte_t  tx_data_i,     // Transmit FIFO head
  input  jsp_pkg::count_t rx_free_i,
  input  jsp_pkg::count_t tx_count_i,
  output logic            tdo_o
);

  jsp_pkg::byte_t sh_q;
  jsp_pkg::byte_t ld_val;

  // Status byte, fill level high and free space low
  assign ld_val = status_sel_i ? {tx_count_i, rx_free_i} : tx_data_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i)
      sh_q <= '0;
    else if (ld_i)
      sh_q <= ld_val;
    else if (shift_i)
      sh_q <= {1'b0, sh_q[jsp_pkg::BYTE_W-1:1]};  // Zero fill from the top
  end

  assign tdo_o = sh_q[0];

endmodule

/* rtl/jsp_ctrl.sv */
/*
 * JTAG serial port control
 * Write FSM moves bytes from TDI into the receive FIFO, read FSM
 * streams status and transmit bytes out through the TDO shifter
 */
`timescale 1ns/1ps

module jsp_ctrl #(
  parameter bit multi_dev_p = 1'b1  // Wait for a '1' start bit before the count word
) (
  input  logic tck_i,
  input  logic rst_i,
  // TAP controller
  input  logic capture_dr_i,
  input  logic shift_dr_i,
  input  logic update_dr_i,
  input  logic module_select_i,
  input  logic tdi_i,
  // Counter status
  input  logic in_zero_i,    // No receive space left
  input  logic out_zero_i,   // No announced bytes left
  input  logic user_zero_i,  // Host has nothing more to send
  // Word counter strobes
  output logic in_ld_o,
  output logic in_dec_o,
  output logic out_ld_o,
  output logic out_dec_o,
  output logic user_ld_o,
  output logic user_dec_o,
  // TDO shifter
  output logic sh_ld_o,
  output logic sh_shift_o,
  output logic sh_status_sel_o,
  // FIFOs
  output logic rx_push_o,
  output logic tx_pop_o
);

  jsp_pkg::wr_state_e wr_state_q, wr_state_d;
  jsp_pkg::rd_state_e rd_state_q, rd_state_d;
  jsp_pkg::bit_cnt_t  wr_bit_q, rd_bit_q;  // Bits seen in the current byte
  logic               wr_bit_clr, wr_bit_inc;
  logic               rd_bit_clr, rd_bit_inc;
  logic               wr_bit_max, rd_bit_max;

  assign wr_bit_max = (wr_bit_q == '1);  // 8th bit on this edge
  assign rd_bit_max = (rd_bit_q == '1);

  ////////////////////////////////////////
  // State and bit counters
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_state_q <= jsp_pkg::WR_IDLE;
      rd_state_q <= jsp_pkg::RD_IDLE;
      wr_bit_q   <= '0;
      rd_bit_q   <= '0;
    end else begin
      wr_state_q <= wr_state_d;
      rd_state_q <= rd_state_d;
      if (wr_bit_clr)
        wr_bit_q <= '0;
      else if (wr_bit_inc)
        wr_bit_q <= wr_bit_q + 1'b1;  // Wraps to zero at byte boundary
      if (rd_bit_clr)
        rd_bit_q <= '0;
      else if (rd_bit_inc)
        rd_bit_q <= rd_bit_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Write FSM
  ////////////////////////////////////////

  always_comb begin
    wr_state_d = wr_state_q;
    wr_bit_clr = 1'b0;
    wr_bit_inc = 1'b0;
    in_ld_o    = 1'b0;
    in_dec_o   = 1'b0;
    user_ld_o  = 1'b0;
    user_dec_o = 1'b0;
    rx_push_o  = 1'b0;
    case (wr_state_q)
      jsp_pkg::WR_IDLE: begin
        if (module_select_i && capture_dr_i) begin
          if (multi_dev_p)
            wr_state_d = jsp_pkg::WR_WAIT;
          else
            wr_state_d = jsp_pkg::WR_COUNTS;
          wr_bit_clr = 1'b1;
          in_ld_o    = 1'b1;  // Snapshot of receive FIFO space
        end
      end
      jsp_pkg::WR_WAIT: begin
        if (update_dr_i)
          wr_state_d = jsp_pkg::WR_IDLE;
        else if (shift_dr_i && module_select_i && tdi_i)
          wr_state_d = jsp_pkg::WR_COUNTS;  // Start bit seen
      end
      jsp_pkg::WR_COUNTS: begin
        if (update_dr_i) begin
          wr_state_d = jsp_pkg::WR_IDLE;
        end else if (shift_dr_i) begin  // Hold during pause
          wr_bit_inc = 1'b1;
          if (wr_bit_max) begin
            wr_state_d = jsp_pkg::WR_XFER;
            user_ld_o  = 1'b1;  // Upper nibble is the host byte count
          end
        end
      end
      jsp_pkg::WR_XFER: begin
        if (update_dr_i) begin
          wr_state_d = jsp_pkg::WR_IDLE;
        end else if (shift_dr_i) begin
          wr_bit_inc = 1'b1;
          // Bytes past either limit are dropped
          if (wr_bit_max && !in_zero_i && !user_zero_i) begin
            rx_push_o  = 1'b1;
            in_dec_o   = 1'b1;
            user_dec_o = 1'b1;
          end
        end
      end
      default: wr_state_d = jsp_pkg::WR_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Read FSM
  ////////////////////////////////////////

  always_comb begin
    rd_state_d      = rd_state_q;
    rd_bit_clr      = 1'b0;
    rd_bit_inc      = 1'b0;
    out_ld_o        = 1'b0;
    out_dec_o       = 1'b0;
    sh_ld_o         = 1'b0;
    sh_shift_o      = 1'b0;
    sh_status_sel_o = (rd_state_q == jsp_pkg::RD_IDLE);  // Status byte only at capture
    tx_pop_o        = 1'b0;
    case (rd_state_q)
      jsp_pkg::RD_IDLE: begin
        if (module_select_i && capture_dr_i) begin
          rd_state_d = jsp_pkg::RD_COUNTS;
          rd_bit_clr = 1'b1;
          sh_ld_o    = 1'b1;
          out_ld_o   = 1'b1;  // Bytes announced in this status byte
        end
      end
      jsp_pkg::RD_COUNTS, jsp_pkg::RD_XFER: begin
        if (update_dr_i) begin
          rd_state_d = jsp_pkg::RD_IDLE;
        end else if (shift_dr_i) begin
          rd_bit_inc = 1'b1;
          sh_shift_o = 1'b1;
          if (rd_bit_max) begin
            rd_state_d = jsp_pkg::RD_RDACK;
            // Next byte replaces the shift, popped later in RD_RDACK
            if (!out_zero_i) begin
              sh_ld_o    = 1'b1;
              sh_shift_o = 1'b0;
              out_dec_o  = (rd_state_q == jsp_pkg::RD_XFER);  // Count lags one byte
            end
          end
        end
      end
      jsp_pkg::RD_RDACK: begin
        if (update_dr_i) begin
          rd_state_d = jsp_pkg::RD_IDLE;
        end else if (shift_dr_i) begin
          rd_state_d = jsp_pkg::RD_XFER;
          rd_bit_inc = 1'b1;
          sh_shift_o = 1'b1;
          tx_pop_o   = !out_zero_i;
        end
      end
      default: rd_state_d = jsp_pkg::RD_IDLE;
    endcase
  end

  // Receive pushes belong to the data phase of a write scan
  a_push_in_xfer : assert property (@(posedge tck_i) disable iff (rst_i)
    rx_push_o |-> (wr_state_q == jsp_pkg::WR_XFER));

  // Transmit pops only acknowledge a byte already in the shifter
  a_pop_in_rdack : assert property (@(posedge tck_i) disable iff (rst_i)
    tx_pop_o |-> (rd_state_q == jsp_pkg::RD_RDACK));

endmodule

/* rtl/jsp_top.sv */
/*
 * JTAG serial port top level
 * Byte channel through one JTAG data register, with receive and
 * transmit FIFOs toward the system in the TCK domain
 */
`timescale 1ns/1ps

module jsp_top #(
  parameter bit multi_dev_p  = 1'b1,  // Start bit before the count word
  parameter int fifo_depth_p = jsp_pkg::FIFO_DEPTH
) (
  input  logic              tck_i,
  input  logic              rst_i,
  // TAP controller
  input  logic              capture_dr_i,
  input  logic              shift_dr_i,
  input  logic              update_dr_i,
  input  logic              module_select_i,
  input  logic              tdi_i,
  input  jsp_pkg::dr_tail_t dr_tail_i,
  output logic              module_tdo_o,
  // System side
  input  logic              sys_rx_pop_i,
  output jsp_pkg::byte_t    sys_rx_data_o,
  output jsp_pkg::count_t   sys_rx_count_o,
  input  logic              sys_tx_push_i,
  input  jsp_pkg::byte_t    sys_tx_data_i,
  output jsp_pkg::count_t   sys_tx_free_o
);

  logic            in_ld, in_dec, out_ld, out_dec, user_ld, user_dec;
  logic            in_zero, out_zero, user_zero;
  logic            sh_ld, sh_shift, sh_status_sel;
  logic            rx_push, tx_pop;
  jsp_pkg::count_t rx_free, tx_count;
  jsp_pkg::byte_t  tx_head;

  jsp_ctrl #(.multi_dev_p(multi_dev_p)) ctrl_inst (
    .tck_i(tck_i), .rst_i(rst_i),
    .capture_dr_i(capture_dr_i), .shift_dr_i(shift_dr_i), .update_dr_i(update_dr_i),
    .module_select_i(module_select_i), .tdi_i(tdi_i),
    .in_zero_i(in_zero), .out_zero_i(out_zero), .user_zero_i(user_zero),
    .in_ld_o(in_ld), .in_dec_o(in_dec), .out_ld_o(out_ld), .out_dec_o(out_dec),
    .user_ld_o(user_ld), .user_dec_o(user_dec),
    .sh_ld_o(sh_ld), .sh_shift_o(sh_shift), .sh_status_sel_o(sh_status_sel),
    .rx_push_o(rx_push), .tx_pop_o(tx_pop)
  );

  jsp_word_counters counters_inst (
    .tck_i(tck_i), .rst_i(rst_i),
    .in_ld_i(in_ld), .in_dec_i(in_dec), .out_ld_i(out_ld), .out_dec_i(out_dec),
    .user_ld_i(user_ld), .user_dec_i(user_dec),
    .rx_free_i(rx_free), .tx_count_i(tx_count), .tdi_i(tdi_i), .dr_tail_i(dr_tail_i),
    .in_zero_o(in_zero), .out_zero_o(out_zero), .user_zero_o(user_zero)
  );

  jsp_tdo_shifter shifter_inst (
    .tck_i(tck_i), .rst_i(rst_i),
    .ld_i(sh_ld), .shift_i(sh_shift), .status_sel_i(sh_status_sel),
    .tx_data_i(tx_head), .rx_free_i(rx_free), .tx_count_i(tx_count),
    .tdo_o(module_tdo_o)
  );

  // Host to system, byte completes with the current TDI bit on top
  jsp_byte_fifo #(.fifo_depth_p(fifo_depth_p)) rx_fifo (
    .tck_i(tck_i), .rst_i(rst_i),
    .push_i(rx_push), .data_i({tdi_i, dr_tail_i}), .pop_i(sys_rx_pop_i),
    .data_o(sys_rx_data_o), .count_o(sys_rx_count_o), .free_o(rx_free)
  );

  // System to host
  jsp_byte_fifo #(.fifo_depth_p(fifo_depth_p)) tx_fifo (
    .tck_i(tck_i), .rst_i(rst_i),
    .push_i(sys_tx_push_i), .data_i(sys_tx_data_i), .pop_i(tx_pop),
    .data_o(tx_head), .count_o(tx_count), .free_o(sys_tx_free_o)
  );

endmodule

/* sim/jsp_tb.sv */
/*
 * JTAG serial port testbench
 * TAP scan driver with DR history, directed write, read and pause tests
 */
`timescale 1ns/1ps

module jsp_tb;

  localparam int SCAN_MAX   = 64;                  // Longest scan in bits
  localparam int WAIT_LIMIT = 50;                  // Cycles per level wait
  localparam int DEPTH      = jsp_pkg::FIFO_DEPTH;

  logic              tck = 1'b0;
  logic              rst;
  logic              capture_dr, shift_dr, update_dr, module_select, tdi;
  jsp_pkg::dr_tail_t dr_tail;
  logic              tdo;
  logic              rx_pop, tx_push;
  jsp_pkg::byte_t    rx_data, tx_data;
  jsp_pkg::count_t   rx_count, tx_free;

  logic [SCAN_MAX-1:0] tdi_bits, tdo_bits;  // Bit i goes out on shift edge i
  int                  nbits;
  logic [7:0]          lfsr_q = 8'd4;

  always #4 tck = ~tck;  // 8 ns period

  jsp_top #(.multi_dev_p(1'b1), .fifo_depth_p(DEPTH)) jsp_top_inst (
    .tck_i(tck), .rst_i(rst),
    .capture_dr_i(capture_dr), .shift_dr_i(shift_dr), .update_dr_i(update_dr),
    .module_select_i(module_select), .tdi_i(tdi), .dr_tail_i(dr_tail),
    .module_tdo_o(tdo),
    .sys_rx_pop_i(rx_pop), .sys_rx_data_o(rx_data), .sys_rx_count_o(rx_count),
    .sys_tx_push_i(tx_push), .sys_tx_data_i(tx_data), .sys_tx_free_o(tx_free)
  );

  ////////////////////////////////////////
  // Error handling and stimulus helpers
  ////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp) else
      stop_on_error($sformatf("MISMATCH %s expected 0x%02h actual 0x%02h", name, exp, act));
  endtask

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    int i;
    for (i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // One step per bit taken
      b[i]   = lfsr_q[0];
    end
  endtask

  task automatic clear_bits();
    nbits    = 0;
    tdi_bits = '0;
  endtask

  // Append the low bits of v, LSB first
  task automatic add_bits(input logic [7:0] v, input int width);
    int i;
    for (i = 0; i < width; i++) begin
      tdi_bits[nbits] = v[i];
      nbits++;
    end
  endtask

  // Wait for a receive or transmit FIFO level on the system side
  task automatic wait_level(input string name, input bit on_tx, input int exp);
    int i;
    bit seen;
    seen = 1'b0;
    for (i = 0; i < WAIT_LIMIT && !seen; i++) begin
      @(negedge tck);
      seen = on_tx ? (tx_free == exp) : (rx_count == exp);
    end
    assert (seen) else
      stop_on_error($sformatf("%s timed out waiting for %s level %0d",
                              name, on_tx ? "transmit free" : "receive fill", exp));
  endtask

  ////////////////////////////////////////
  // TAP scan and system side drivers
  ////////////////////////////////////////

  // Capture, shift nbits with an optional pause, then update
  task automatic run_scan(input int pause_at, input int pause_len);
    int i;
    jsp_pkg::dr_tail_t hist;
    hist = '0;
    @(posedge tck);
    capture_dr <= 1'b1;
    @(posedge tck);
    capture_dr <= 1'b0;
    for (i = 0; i < nbits; i++) begin
      if (i == pause_at) begin
        shift_dr <= 1'b0;  // FSMs must hold in Pause-DR
        repeat (pause_len) @(posedge tck);
      end
      shift_dr <= 1'b1;
      tdi      <= tdi_bits[i];
      dr_tail  <= hist;                   // Previous TDI bits with the newest on top
      hist      = {tdi_bits[i], hist[6:1]};
      @(negedge tck);
      tdo_bits[i] = tdo;                  // Bit leaving on the coming edge
      @(posedge tck);
    end
    shift_dr  <= 1'b0;
    update_dr <= 1'b1;
    @(posedge tck);
    update_dr <= 1'b0;
  endtask

  task automatic pop_rx_check(input string name, input jsp_pkg::byte_t exp);
    @(negedge tck);
    check_val(name, exp, rx_data);  // FIFO head before the pop
    @(posedge tck);
    rx_pop <= 1'b1;
    @(posedge tck);
    rx_pop <= 1'b0;
  endtask

  task automatic push_tx(input jsp_pkg::byte_t b);
    @(posedge tck);
    tx_push <= 1'b1;
    tx_data <= b;
    @(posedge tck);
    tx_push <= 1'b0;
  endtask

  // Zeros, start bit, count word, then n_send random bytes
  task automatic do_write_scan(input string name, input logic [3:0] nibble,
                               input int n_send, input int n_expect, input int pause_at);
    jsp_pkg::byte_t data [4];
    int k;
    clear_bits();
    add_bits(8'h00, 3);
    add_bits(8'h01, 1);
    add_bits({nibble, 4'h0}, 8);
    for (k = 0; k < n_send; k++) begin
      next_rand_byte(data[k]);
      add_bits(data[k], 8);
    end
    run_scan(pause_at, 5);
    check_val({name, " status"}, {4'h0, jsp_pkg::count_t'(DEPTH)}, tdo_bits[7:0]);
    wait_level(name, 1'b0, n_expect);
    for (k = 0; k < n_expect; k++)
      pop_rx_check(name, data[k]);  // Arrival order
    wait_level(name, 1'b0, 0);
  endtask

  // System pushes n_bytes and the host reads status then the bytes
  task automatic do_read_scan(input string name, input int n_bytes, input int pause_at);
    jsp_pkg::byte_t data [4];
    int k;
    for (k = 0; k < n_bytes; k++) begin
      next_rand_byte(data[k]);
      push_tx(data[k]);
    end
    wait_level(name, 1'b1, DEPTH - n_bytes);
    clear_bits();
    add_bits(8'h00, 8);
    for (k = 0; k < n_bytes; k++)
      add_bits(8'h00, 8);
    run_scan(pause_at, 6);
    check_val({name, " status"},
              {jsp_pkg::count_t'(n_bytes), jsp_pkg::count_t'(DEPTH)}, tdo_bits[7:0]);
    for (k = 0; k < n_bytes; k++)
      check_val(name, data[k], tdo_bits[8 + 8*k +: 8]);
    wait_level(name, 1'b1, DEPTH);  // All popped
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_status();
    clear_bits();
    add_bits(8'h00, 8);
    run_scan(-1, 0);
    check_val("reset status", {4'h0, jsp_pkg::count_t'(DEPTH)}, tdo_bits[7:0]);
    @(negedge tck);
    check_val("reset rx count", 8'h00, {4'h0, rx_count});
  endtask

  task automatic test_write();
    do_write_scan("write", 4'd3, 3, 3, -1);
  endtask

  task automatic test_host_limit();
    do_write_scan("host limit", 4'd2, 4, 2, -1);  // Last two bytes dropped
  endtask

  task automatic test_read();
    do_read_scan("read", 3, -1);
  endtask

  task automatic test_pause();
    do_write_scan("pause write", 4'd3, 3, 3, 15);  // Mid first data byte
    do_read_scan("pause read", 3, 20);             // Mid second data byte
  endtask

  initial begin
    rst           = 1'b1;
    capture_dr    = 1'b0;
    shift_dr      = 1'b0;
    update_dr     = 1'b0;
    module_select = 1'b0;
    tdi           = 1'b0;
    dr_tail       = '0;
    rx_pop        = 1'b0;
    tx_push       = 1'b0;
    tx_data       = '0;
    repeat (3) @(posedge tck);
    rst           <= 1'b0;
    module_select <= 1'b1;
    test_reset_status();
    test_write();
    test_host_limit();
    test_read();
    test_pause();
    $display("test passed");
    $finish;
  end

endmodule

/* jsp_link.f */
rtl/jsp_pkg.sv
rtl/jsp_byte_fifo.sv
rtl/jsp_word_counters.sv
rtl/jsp_tdo_shifter.sv
rtl/jsp_ctrl.sv
rtl/jsp_top.sv
sim/jsp_tb.sv
